//--- include/axi_defs.svh
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Address and data path widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// One strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// AWLEN field, holds beat count minus one
`define AXI_LEN_W 8

// BRESP field
`define AXI_RESP_W 2

// Fixed-value AW fields
`define AXI_SIZE_W  3
`define AXI_BURST_W 2
`define AXI_CACHE_W 4
`define AXI_PROT_W  3

// Native beat buffer in front of the controller
`define IN_FIFO_DEPTH 4

// W beat buffer on the AXI side
`define W_FIFO_DEPTH 2

`endif

//--- hdl/axi_pkg.sv
`default_nettype none

`include "axi_defs.svh"

package axi_pkg;

   // Address request, one per burst
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
   } aw_req_t;

   // One W channel beat
   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;
      logic [`AXI_STRB_W-1:0] strb;
      logic                   last;
   } w_beat_t;

   // BRESP encodings
   typedef enum logic [`AXI_RESP_W-1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } resp_t;

   // Fixed field values, only INCR bursts are issued
   localparam logic [`AXI_BURST_W-1:0] BURST_INCR = 2'b01;
   localparam logic [`AXI_CACHE_W-1:0] CACHE_BUF  = 4'b0010;
   localparam logic [`AXI_PROT_W-1:0]  PROT_DATA  = 3'b010;

endpackage

`default_nettype wire

//--- hdl/iob_pkg.sv
`default_nettype none

`include "axi_defs.svh"

package iob_pkg;

   // Beat as presented on the native write port
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_DATA_W-1:0] data;
      logic [`AXI_STRB_W-1:0] strb;
   } nat_beat_t;

   // Burst controller states
   typedef enum logic [1:0] {
      ADDR_HS    = 2'h0,
      WRITE      = 2'h1,
      W_RESPONSE = 2'h2
   } wr_state_t;

endpackage

`default_nettype wire

//--- hdl/beat_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module beat_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  wire           clk,
   input  wire           rst,
   input  wire           push,
   input  wire payload_t push_data,
   output logic          full,
   input  wire           pop,
   output logic          pop_valid,
   output payload_t      pop_data
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Pointer advance with wrap for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign full      = (count == CNT_W'(DEPTH));
   assign pop_valid = (count != '0);
   assign pop_data  = mem[rd_ptr];

   // Full blocks push even when a pop happens in the same cycle
   assign do_push = push && !full;
   assign do_pop  = pop && pop_valid;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/axi_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface axi_wr_if;

   // Write address channel
   logic             aw_valid;
   logic             aw_ready;
   axi_pkg::aw_req_t aw_req;

   // Write data channel
   logic             w_valid;
   logic             w_ready;
   axi_pkg::w_beat_t w_beat;

   // Write response channel
   logic             b_valid;
   logic             b_ready;
   axi_pkg::resp_t   b_resp;

   modport ctrl (
      output aw_valid, aw_req, w_valid, w_beat, b_ready,
      input  aw_ready, w_ready, b_valid, b_resp
   );

   modport port (
      input  aw_valid, aw_req, w_valid, w_beat, b_ready,
      output aw_ready, w_ready, b_valid, b_resp
   );

endinterface

`default_nettype wire

//--- hdl/burst_wr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_defs.svh"

module burst_wr_ctrl (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     head_valid,
   input  wire iob_pkg::nat_beat_t head_beat,
   output logic                    pop,
   input  wire [`AXI_LEN_W-1:0]    length,
   output logic                    ready,
   output logic                    error,
   axi_wr_if.ctrl                  axi
);

   iob_pkg::wr_state_t     state;
   iob_pkg::wr_state_t     state_nxt;

   // Burst parameters captured when a burst opens
   logic [`AXI_ADDR_W-1:0] addr_reg;
   logic [`AXI_LEN_W-1:0]  len_reg;

   logic [`AXI_LEN_W-1:0]  beat_cnt;
   logic                   aw_pending;
   logic                   open_burst;
   logic                   beat_move;
   logic                   last_beat;
   logic                   resp_done;

   assign open_burst = (state == iob_pkg::ADDR_HS) && head_valid;
   assign beat_move  = (state == iob_pkg::WRITE) && head_valid && axi.w_ready;
   assign last_beat  = (beat_cnt == len_reg);
   assign resp_done  = (state == iob_pkg::W_RESPONSE) && axi.b_valid;

   // Idle and nothing waiting in the input buffer
   assign ready = (state == iob_pkg::ADDR_HS) && !head_valid;
   assign pop   = beat_move;

   // AW request stays up until the output side takes it
   assign axi.aw_valid = aw_pending;
   assign axi.aw_req   = '{addr: addr_reg, len: len_reg};

   // Head of the input FIFO goes straight onto W
   assign axi.w_valid = (state == iob_pkg::WRITE) && head_valid;
   assign axi.w_beat  = '{data: head_beat.data, strb: head_beat.strb, last: last_beat};

   assign axi.b_ready = (state == iob_pkg::W_RESPONSE);

   always_comb begin
      state_nxt = state;
      case (state)
         iob_pkg::ADDR_HS: begin
            if (head_valid) begin
               state_nxt = iob_pkg::WRITE;
            end
         end
         iob_pkg::WRITE: begin
            if (beat_move && last_beat) begin
               state_nxt = iob_pkg::W_RESPONSE;
            end
         end
         iob_pkg::W_RESPONSE: begin
            if (axi.b_valid) begin
               state_nxt = iob_pkg::ADDR_HS;
            end
         end
         default: begin
            state_nxt = iob_pkg::ADDR_HS;
         end
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= iob_pkg::ADDR_HS;
      end else begin
         state <= state_nxt;
      end
   end

   // Start address comes from the first beat of the burst
   always_ff @(posedge clk) begin
      if (open_burst) begin
         addr_reg <= head_beat.addr;
         len_reg  <= length;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         beat_cnt   <= '0;
         aw_pending <= 1'b0;
         error      <= 1'b0;
      end else begin
         if (open_burst) begin
            beat_cnt <= '0;
         end else if (beat_move) begin
            beat_cnt <= beat_cnt + 1'b1;
         end

         if (open_burst) begin
            aw_pending <= 1'b1;
         end else if (axi.aw_ready) begin
            aw_pending <= 1'b0;
         end

         // Any nonzero response flags the burst as failed
         if (resp_done) begin
            error <= |axi.b_resp;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/axi_wr_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_defs.svh"

module axi_wr_port (
   input  wire                    clk,
   input  wire                    rst,
   axi_wr_if.port                 axi,
   output logic                   awvalid,
   input  wire                    awready,
   output logic [`AXI_ADDR_W-1:0] awaddr,
   output logic [`AXI_LEN_W-1:0]  awlen,
   output logic [`AXI_SIZE_W-1:0] awsize,
   output logic [`AXI_BURST_W-1:0] awburst,
   output logic [`AXI_CACHE_W-1:0] awcache,
   output logic [`AXI_PROT_W-1:0] awprot,
   output logic                   wvalid,
   input  wire                    wready,
   output logic [`AXI_DATA_W-1:0] wdata,
   output logic [`AXI_STRB_W-1:0] wstrb,
   output logic                   wlast,
   input  wire                    bvalid,
   output logic                   bready,
   input  wire [`AXI_RESP_W-1:0]  bresp
);

   // Full-width transfers only
   localparam logic [`AXI_SIZE_W-1:0] AW_SIZE = `AXI_SIZE_W'($clog2(`AXI_STRB_W));

   logic             aw_full;
   axi_pkg::aw_req_t aw_hold;
   logic             w_full;
   axi_pkg::w_beat_t w_head;

   // One-entry AW register
   assign axi.aw_ready = !aw_full;

   always_ff @(posedge clk) begin
      if (axi.aw_valid && !aw_full) begin
         aw_hold <= axi.aw_req;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         aw_full <= 1'b0;
      end else if (!aw_full) begin
         aw_full <= axi.aw_valid;
      end else if (awready) begin
         aw_full <= 1'b0;
      end
   end

   assign awvalid = aw_full;
   assign awaddr  = aw_hold.addr;
   assign awlen   = aw_hold.len;
   assign awsize  = AW_SIZE;
   assign awburst = axi_pkg::BURST_INCR;
   assign awcache = axi_pkg::CACHE_BUF;
   assign awprot  = axi_pkg::PROT_DATA;

   // W beats decoupled from the controller
   beat_fifo #(
      .payload_t (axi_pkg::w_beat_t),
      .DEPTH     (`W_FIFO_DEPTH)
   ) w_fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .push      (axi.w_valid),
      .push_data (axi.w_beat),
      .full      (w_full),
      .pop       (wready),
      .pop_valid (wvalid),
      .pop_data  (w_head)
   );

   assign axi.w_ready = !w_full;
   assign wdata       = w_head.data;
   assign wstrb       = w_head.strb;
   assign wlast       = w_head.last;

   // B passes through unbuffered
   assign axi.b_valid = bvalid;
   assign axi.b_resp  = axi_pkg::resp_t'(bresp);
   assign bready      = axi.b_ready;

endmodule

`default_nettype wire

//--- hdl/iob2axi_wr_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_defs.svh"

module iob2axi_wr_top (
   input  wire                     clk,
   input  wire                     rst,
   // Control
   input  wire [`AXI_LEN_W-1:0]    length,
   output logic                    ready,
   output logic                    error,
   // Native write port
   input  wire                     s_valid,
   input  wire [`AXI_ADDR_W-1:0]   s_addr,
   input  wire [`AXI_DATA_W-1:0]   s_wdata,
   input  wire [`AXI_STRB_W-1:0]   s_wstrb,
   output logic                    s_ready,
   // AXI write master
   output logic                    awvalid,
   input  wire                     awready,
   output logic [`AXI_ADDR_W-1:0]  awaddr,
   output logic [`AXI_LEN_W-1:0]   awlen,
   output logic [`AXI_SIZE_W-1:0]  awsize,
   output logic [`AXI_BURST_W-1:0] awburst,
   output logic [`AXI_CACHE_W-1:0] awcache,
   output logic [`AXI_PROT_W-1:0]  awprot,
   output logic                    wvalid,
   input  wire                     wready,
   output logic [`AXI_DATA_W-1:0]  wdata,
   output logic [`AXI_STRB_W-1:0]  wstrb,
   output logic                    wlast,
   input  wire                     bvalid,
   output logic                    bready,
   input  wire [`AXI_RESP_W-1:0]   bresp
);

   iob_pkg::nat_beat_t in_beat;
   iob_pkg::nat_beat_t head_beat;
   logic               in_full;
   logic               head_valid;
   logic               head_pop;

   axi_wr_if axi_wr ();

   assign in_beat = '{addr: s_addr, data: s_wdata, strb: s_wstrb};
   assign s_ready = !in_full;

   beat_fifo #(
      .payload_t (iob_pkg::nat_beat_t),
      .DEPTH     (`IN_FIFO_DEPTH)
   ) in_fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .push      (s_valid),
      .push_data (in_beat),
      .full      (in_full),
      .pop       (head_pop),
      .pop_valid (head_valid),
      .pop_data  (head_beat)
   );

   burst_wr_ctrl burst_wr_ctrl_inst (
      .clk        (clk),
      .rst        (rst),
      .head_valid (head_valid),
      .head_beat  (head_beat),
      .pop        (head_pop),
      .length     (length),
      .ready      (ready),
      .error      (error),
      .axi        (axi_wr.ctrl)
   );

   axi_wr_port axi_wr_port_inst (
      .clk     (clk),
      .rst     (rst),
      .axi     (axi_wr.port),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .awlen   (awlen),
      .awsize  (awsize),
      .awburst (awburst),
      .awcache (awcache),
      .awprot  (awprot),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wlast   (wlast),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp)
   );

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset released on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- verif/iob2axi_wr_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_defs.svh"

module iob2axi_wr_tb;

   localparam int N_BURSTS = 6;

   // One row per burst, stimulus and expected error flag
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
      logic [`AXI_DATA_W-1:0] data0;
      logic [`AXI_STRB_W-1:0] strb;
      axi_pkg::resp_t         resp;
      logic                   stall;
      logic                   exp_err;
   } burst_t;

   logic clk;
   logic rst;
   logic [`AXI_LEN_W-1:0]   length;
   logic                    ready;
   logic                    error;
   logic                    s_valid;
   logic [`AXI_ADDR_W-1:0]  s_addr;
   logic [`AXI_DATA_W-1:0]  s_wdata;
   logic [`AXI_STRB_W-1:0]  s_wstrb;
   logic                    s_ready;
   logic                    awvalid;
   logic                    awready;
   logic [`AXI_ADDR_W-1:0]  awaddr;
   logic [`AXI_LEN_W-1:0]   awlen;
   logic [`AXI_SIZE_W-1:0]  awsize;
   logic [`AXI_BURST_W-1:0] awburst;
   logic [`AXI_CACHE_W-1:0] awcache;
   logic [`AXI_PROT_W-1:0]  awprot;
   logic                    wvalid;
   logic                    wready;
   logic [`AXI_DATA_W-1:0]  wdata;
   logic [`AXI_STRB_W-1:0]  wstrb;
   logic                    wlast;
   logic                    bvalid;
   logic                    bready;
   logic [`AXI_RESP_W-1:0]  bresp;

   burst_t bursts [N_BURSTS];
   integer rnd_seed;
   int     mismatch_cnt = 0;
   int     other_cnt = 0;
   int     aw_count = 0;
   int     w_burst = 0;
   int     w_beat = 0;
   int     beat_count = 0;

   tb_clkgen #(.PERIOD(40), .RESET_CYCLES(5)) clkgen_inst (.clk(clk), .rst(rst));

   iob2axi_wr_top iob2axi_wr_top_inst (.*);

   task automatic load_table();
      bursts[0] = '{32'h0000_1000, 8'd3,  32'h1111_0000, 4'hf, axi_pkg::RESP_OKAY,   1'b0, 1'b0};
      bursts[1] = '{32'h0000_2040, 8'd0,  32'h2222_0000, 4'h3, axi_pkg::RESP_SLVERR, 1'b0, 1'b1};
      bursts[2] = '{32'h0001_0000, 8'd7,  32'h3333_0000, 4'hf, axi_pkg::RESP_OKAY,   1'b1, 1'b0};
      bursts[3] = '{32'h0000_3000, 8'd5,  32'h4444_0000, 4'hc, axi_pkg::RESP_DECERR, 1'b1, 1'b1};
      bursts[4] = '{32'h0000_4100, 8'd15, 32'h5555_0000, 4'hf, axi_pkg::RESP_EXOKAY, 1'b1, 1'b1};
      bursts[5] = '{32'h0000_5000, 8'd2,  32'h6666_0000, 4'h5, axi_pkg::RESP_OKAY,   1'b0, 1'b0};
   endtask

   function automatic logic [`AXI_DATA_W-1:0] beat_data(input int k, input int i);
      return bursts[k].data0 + 32'(i) * 32'h0001_0003;
   endfunction

   function automatic int total_beats();
      int sum;
      sum = 0;
      for (int k = 0; k < N_BURSTS; k++) begin
         sum += bursts[k].len + 1;
      end
      return sum;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
         mismatch_cnt++;
      end
   endtask

   task automatic report_and_finish();
      $display("error counts: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   // Native beats, one burst after the other
   task automatic drive_bursts();
      for (int k = 0; k < N_BURSTS; k++) begin
         @(negedge clk);
         length = bursts[k].len;
         for (int i = 0; i <= bursts[k].len; i++) begin
            s_valid = 1'b1;
            s_addr  = bursts[k].addr + 32'(4 * i);
            s_wdata = beat_data(k, i);
            s_wstrb = bursts[k].strb;
            // s_ready is stable between rising edges
            while (!s_ready) @(negedge clk);
            @(negedge clk);
         end
         s_valid = 1'b0;
         // Length must hold until this burst has opened
         while (aw_count <= k) @(negedge clk);
      end
   endtask

   // B answer once both AW and the last W beat of a burst are through
   task automatic answer_bursts();
      for (int k = 0; k < N_BURSTS; k++) begin
         while (w_burst <= k || aw_count <= k) @(negedge clk);
         // Controller is already waiting for the response
         check_value("bready", 32'd1, 32'(bready));
         bvalid = 1'b1;
         bresp  = bursts[k].resp;
         while (!bready) @(negedge clk);
         @(negedge clk);
         bvalid = 1'b0;
         check_value("error", 32'(bursts[k].exp_err), 32'(error));
      end
   endtask

   always @(posedge clk) begin
      if (!rst && awvalid && awready) begin
         assert (aw_count < N_BURSTS) else begin
            $display("unexpected AW request at %0t after the last burst", $time);
            other_cnt++;
         end
         if (aw_count < N_BURSTS) begin
            check_value("awaddr", bursts[aw_count].addr, awaddr);
            check_value("awlen", 32'(bursts[aw_count].len), 32'(awlen));
         end
         // Four bytes per beat
         check_value("awsize", 32'd2, 32'(awsize));
         check_value("awburst", 32'(axi_pkg::BURST_INCR), 32'(awburst));
         check_value("awcache", 32'(axi_pkg::CACHE_BUF), 32'(awcache));
         check_value("awprot", 32'(axi_pkg::PROT_DATA), 32'(awprot));
         aw_count++;
      end
   end

   always @(posedge clk) begin
      if (!rst && wvalid && wready) begin
         beat_count++;
         assert (w_burst < N_BURSTS) else begin
            $display("unexpected W beat at %0t after the last burst", $time);
            other_cnt++;
         end
         if (w_burst < N_BURSTS) begin
            check_value("wdata", beat_data(w_burst, w_beat), wdata);
            check_value("wstrb", 32'(bursts[w_burst].strb), 32'(wstrb));
            check_value("wlast", 32'(w_beat == bursts[w_burst].len), 32'(wlast));
            if (w_beat == bursts[w_burst].len) begin
               w_burst++;
               w_beat = 0;
            end else begin
               w_beat++;
            end
         end
      end
   end

   // Random wready stalls on the rows that ask for them
   always @(negedge clk) begin
      if (rst) begin
         wready = 1'b0;
      end else if (w_burst < N_BURSTS && bursts[w_burst].stall) begin
         wready = ($random(rnd_seed) & 3) != 0;
      end else begin
         wready = 1'b1;
      end
   end

   initial begin
      length   = '0;
      s_valid  = 1'b0;
      s_addr   = '0;
      s_wdata  = '0;
      s_wstrb  = '0;
      awready  = 1'b0;
      wready   = 1'b0;
      bvalid   = 1'b0;
      bresp    = '0;
      rnd_seed = 32'hcd38;
      load_table();
      @(negedge rst);
      @(negedge clk);
      check_value("ready", 32'd1, 32'(ready));
      check_value("error", 32'd0, 32'(error));
      check_value("awvalid", 32'd0, 32'(awvalid));
      check_value("wvalid", 32'd0, 32'(wvalid));
      awready = 1'b1;
      fork
         drive_bursts();
         answer_bursts();
      join
      @(negedge clk);
      check_value("ready", 32'd1, 32'(ready));
      check_value("W beat count", total_beats(), beat_count);
      check_value("AW count", N_BURSTS, aw_count);
      report_and_finish();
   end

   // Limit scales with the number of beats in the table
   initial begin
      int limit;
      @(negedge rst);
      limit = total_beats() * 40 + 200;
      repeat (limit) @(posedge clk);
      $display("timeout: bursts still open after %0d cycles", limit);
      other_cnt++;
      report_and_finish();
   end

endmodule

`default_nettype wire

//--- iob2axi_wr_top.f
+incdir+include
hdl/axi_pkg.sv
hdl/iob_pkg.sv
hdl/beat_fifo.sv
hdl/axi_wr_if.sv
hdl/burst_wr_ctrl.sv
hdl/axi_wr_port.sv
hdl/iob2axi_wr_top.sv
verif/tb_clkgen.sv
verif/iob2axi_wr_tb.sv
